//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_sya -f sim.f \
		-Mdir obj_dir -o tb_sya

run: compile
	./obj_dir/tb_sya | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/sya_ctrl.sv
// Command and tile sequencing

`timescale 1ns/10ps

module sya_ctrl
  import sya_pkg::*;
#(
  parameter int NUM_ROW    = 4,
  parameter int NUM_COL    = 4,
  parameter int ADDR_WIDTH = 16,
  parameter int CHN_WIDTH  = 10
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_vld_i,
  output logic                   cfg_rdy_o,
  input  logic [ADDR_WIDTH-1:0]  cfg_nip_i,
  input  logic [CHN_WIDTH-1:0]   cfg_chi_i,
  input  logic [SCALE_WIDTH-1:0] cfg_scale_i,
  input  logic [SHIFT_WIDTH-1:0] cfg_shift_i,
  input  logic [ACT_WIDTH-1:0]   cfg_zp_i,
  input  logic [ADDR_WIDTH-1:0]  cfg_act_base_i,
  input  logic [ADDR_WIDTH-1:0]  cfg_wgt_base_i,
  input  logic [ADDR_WIDTH-1:0]  cfg_ofm_base_i,
  output logic [ADDR_WIDTH-1:0]  act_addr_o,
  output logic [ADDR_WIDTH-1:0]  wgt_addr_o,
  output logic                   rd_addr_vld_o,
  input  logic                   act_addr_rdy_i,
  input  logic                   wgt_addr_rdy_i,
  input  logic                   act_dat_vld_i,
  output logic                   act_dat_rdy_o,
  input  logic                   wgt_dat_vld_i,
  output logic                   wgt_dat_rdy_o,
  output logic                   array_step_o,
  output logic                   array_clear_o,
  output logic                   feed_vld_o,
  output logic                   tile_ready_o,
  input  logic                   tile_written_i,
  output logic [SCALE_WIDTH-1:0] scale_o,
  output logic [SHIFT_WIDTH-1:0] shift_o,
  output logic [ACT_WIDTH-1:0]   zp_o,
  output logic [ADDR_WIDTH-1:0]  ofm_base_o
);

  localparam int DRAIN_STEPS = NUM_ROW + NUM_COL - 2;
  localparam int DRN_WIDTH   = $clog2(NUM_ROW + NUM_COL);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_LOAD  = 2'd1;
  localparam logic [1:0] S_DRAIN = 2'd2;
  localparam logic [1:0] S_WRITE = 2'd3;

  logic [1:0]            state_q, state_d;
  logic [ADDR_WIDTH-1:0] nip_q, tile_cnt_q, addr_cnt_q;
  logic [CHN_WIDTH-1:0]  chi_q, addr_tile_q, beat_cnt_q;
  logic [DRN_WIDTH-1:0]  drain_cnt_q;
  logic [ADDR_WIDTH-1:0] act_base_q, wgt_base_q;
  logic                  tile_ready_q;
  logic                  cfg_fire, addr_fire, beat_ok, beat_fire;
  logic                  last_beat, drain_last, last_tile, next_tile;

  //====================================================================
  // Handshakes
  //====================================================================
  assign cfg_rdy_o     = (state_q == S_IDLE);
  assign cfg_fire      = cfg_vld_i & cfg_rdy_o;
  assign rd_addr_vld_o = (state_q == S_LOAD) && (addr_tile_q < chi_q);
  assign addr_fire     = rd_addr_vld_o & act_addr_rdy_i & wgt_addr_rdy_i;
  assign act_addr_o    = act_base_q + addr_cnt_q;
  assign wgt_addr_o    = wgt_base_q + addr_cnt_q;

  // A channel beat needs both buffers valid together
  assign beat_ok       = (state_q == S_LOAD) && (beat_cnt_q < chi_q);
  assign act_dat_rdy_o = wgt_dat_vld_i & beat_ok;
  assign wgt_dat_rdy_o = act_dat_vld_i & beat_ok;
  assign beat_fire     = act_dat_vld_i & wgt_dat_vld_i & beat_ok;

  assign last_beat  = beat_fire && (beat_cnt_q == chi_q - 1'b1);
  assign drain_last = (drain_cnt_q == DRN_WIDTH'(DRAIN_STEPS - 1));
  assign last_tile  = (tile_cnt_q == nip_q - 1'b1);
  assign next_tile  = (state_q == S_WRITE) && tile_written_i && !last_tile;

  assign array_step_o  = beat_fire | (state_q == S_DRAIN);
  assign feed_vld_o    = beat_fire;
  assign array_clear_o = cfg_fire | next_tile;  // Fresh accumulators per tile
  assign tile_ready_o  = tile_ready_q;

  //====================================================================
  // Tile FSM
  //====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (cfg_fire) state_d = S_LOAD;
      S_LOAD:  if (last_beat) state_d = (DRAIN_STEPS == 0) ? S_WRITE : S_DRAIN;
      S_DRAIN: if (drain_last) state_d = S_WRITE;
      S_WRITE: if (tile_written_i) state_d = last_tile ? S_IDLE : S_LOAD;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= S_IDLE;
      nip_q        <= '0;
      chi_q        <= '0;
      tile_cnt_q   <= '0;
      addr_cnt_q   <= '0;
      addr_tile_q  <= '0;
      beat_cnt_q   <= '0;
      drain_cnt_q  <= '0;
      tile_ready_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      tile_ready_q <= ((state_q == S_DRAIN) && drain_last) ||
                      (last_beat && (DRAIN_STEPS == 0));
      if (cfg_fire) begin
        nip_q       <= cfg_nip_i;
        chi_q       <= cfg_chi_i;
        tile_cnt_q  <= '0;
        addr_cnt_q  <= '0;
        addr_tile_q <= '0;
        beat_cnt_q  <= '0;
      end
      if (addr_fire) begin
        addr_cnt_q  <= addr_cnt_q + 1'b1;   // Runs over the whole command
        addr_tile_q <= addr_tile_q + 1'b1;
      end
      if (beat_fire) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      if (next_tile) begin
        tile_cnt_q  <= tile_cnt_q + 1'b1;
        addr_tile_q <= '0;
        beat_cnt_q  <= '0;
      end
      drain_cnt_q <= (state_q == S_DRAIN) ? drain_cnt_q + 1'b1 : '0;
    end
  end

  // Command parameters, ofm base steps one tile of rows at a time
  always_ff @(posedge clk) begin
    if (cfg_fire) begin
      scale_o    <= cfg_scale_i;
      shift_o    <= cfg_shift_i;
      zp_o       <= cfg_zp_i;
      act_base_q <= cfg_act_base_i;
      wgt_base_q <= cfg_wgt_base_i;
      ofm_base_o <= cfg_ofm_base_i;
    end else if (next_tile) begin
      ofm_base_o <= ofm_base_o + ADDR_WIDTH'(NUM_ROW);
    end
  end

endmodule

//--- hw/sya_ofm_writer.sv
// Output quantization and write-back

`timescale 1ns/10ps

module sya_ofm_writer
  import sya_pkg::*;
#(
  parameter  int NUM_ROW    = 4,
  parameter  int NUM_COL    = 4,
  parameter  int ADDR_WIDTH = 16,
  localparam int SEL_WIDTH  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         tile_ready_i,
  input  logic [ACC_WIDTH*NUM_COL-1:0] row_acc_i,
  input  logic [SCALE_WIDTH-1:0]       scale_i,
  input  logic [SHIFT_WIDTH-1:0]       shift_i,
  input  logic [ACT_WIDTH-1:0]         zp_i,
  input  logic [ADDR_WIDTH-1:0]        ofm_base_i,
  input  logic                         ofm_rdy_i,
  output logic [SEL_WIDTH-1:0]         row_sel_o,
  output logic [ACT_WIDTH*NUM_COL-1:0] ofm_dat_o,
  output logic [ADDR_WIDTH-1:0]        ofm_addr_o,
  output logic                         ofm_vld_o,
  output logic                         tile_written_o
);

  localparam int PROD_WIDTH = ACC_WIDTH + SCALE_WIDTH + 1;

  logic                  busy_q;
  logic [SEL_WIDTH-1:0]  row_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  row_fire, last_row;

  // acc * scale, floor shift, add zero point, clamp to int8
  function automatic logic [ACT_WIDTH-1:0] quantize(
    input logic signed [ACC_WIDTH-1:0] acc,
    input logic [SCALE_WIDTH-1:0]      scale,
    input logic [SHIFT_WIDTH-1:0]      shift,
    input logic signed [ACT_WIDTH-1:0] zp
  );
    logic signed [PROD_WIDTH-1:0] prod;
    logic signed [PROD_WIDTH:0]   sum;
    prod = acc * $signed({1'b0, scale});
    prod = prod >>> shift;
    sum  = prod + zp;
    if (sum > QMAX) begin
      return QMAX;
    end else if (sum < QMIN) begin
      return QMIN;
    end
    return sum[ACT_WIDTH-1:0];
  endfunction

  //====================================================================
  // Row sequencing
  //====================================================================
  assign row_fire       = busy_q & ofm_rdy_i;
  assign last_row       = (row_q == SEL_WIDTH'(NUM_ROW - 1));
  assign tile_written_o = row_fire & last_row;
  assign ofm_vld_o      = busy_q;
  assign row_sel_o      = row_q;
  assign ofm_addr_o     = addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      row_q  <= '0;
      addr_q <= '0;
    end else if (tile_ready_i) begin
      busy_q <= 1'b1;        // Row 0 goes out next cycle
      row_q  <= '0;
      addr_q <= ofm_base_i;  // Tile base from the controller
    end else if (row_fire) begin
      addr_q <= addr_q + 1'b1;
      if (last_row) begin
        busy_q <= 1'b0;
      end else begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  // One quantizer per column lane
  for (genvar c = 0; c < NUM_COL; c++) begin : g_lane
    assign ofm_dat_o[c*ACT_WIDTH +: ACT_WIDTH] =
      quantize(row_acc_i[c*ACC_WIDTH +: ACC_WIDTH], scale_i, shift_i, zp_i);
  end

endmodule

//--- hw/sya_pe.sv
// Multiply-accumulate cell

`timescale 1ns/10ps

module sya_pe
  import sya_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        step_i,
  input  logic                        clear_i,
  input  logic                        vld_i,
  input  logic signed [ACT_WIDTH-1:0] act_i,
  input  logic signed [ACT_WIDTH-1:0] wgt_i,
  output logic                        vld_o,
  output logic signed [ACT_WIDTH-1:0] act_o,
  output logic signed [ACT_WIDTH-1:0] wgt_o,
  output logic signed [ACC_WIDTH-1:0] acc_o
);

  // Valid bit travels right with the activation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_o <= 1'b0;
    end else if (step_i) begin
      vld_o <= vld_i;
    end
  end

  // Operand forwarding, activation right and weight down
  always_ff @(posedge clk) begin
    if (step_i) begin
      act_o <= act_i;
      wgt_o <= wgt_i;
    end
  end

  always_ff @(posedge clk) begin
    if (clear_i) begin
      acc_o <= '0;
    end else if (step_i && vld_i) begin
      acc_o <= acc_o + act_i * wgt_i;  // Signed MAC
    end
  end

endmodule

//--- hw/sya_pe_array.sv
// Skewed PE grid with row readout

`timescale 1ns/10ps

module sya_pe_array
  import sya_pkg::*;
#(
  parameter  int NUM_ROW   = 4,
  parameter  int NUM_COL   = 4,
  localparam int SEL_WIDTH = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         step_i,
  input  logic                         clear_i,
  input  logic                         feed_vld_i,
  input  logic [ACT_WIDTH*NUM_ROW-1:0] act_dat_i,
  input  logic [ACT_WIDTH*NUM_COL-1:0] wgt_dat_i,
  input  logic [SEL_WIDTH-1:0]         row_sel_i,
  output logic [ACC_WIDTH*NUM_COL-1:0] row_acc_o
);

  logic signed [ACT_WIDTH-1:0] row_act [NUM_ROW];   // Skewed activation per row
  logic                        row_vld [NUM_ROW];
  logic signed [ACT_WIDTH-1:0] col_wgt [NUM_COL];   // Skewed weight per column

  logic signed [ACT_WIDTH-1:0] act_in  [NUM_ROW][NUM_COL];
  logic                        vld_in  [NUM_ROW][NUM_COL];
  logic signed [ACT_WIDTH-1:0] wgt_in  [NUM_ROW][NUM_COL];
  logic signed [ACT_WIDTH-1:0] act_out [NUM_ROW][NUM_COL];
  logic                        vld_out [NUM_ROW][NUM_COL];
  logic signed [ACT_WIDTH-1:0] wgt_out [NUM_ROW][NUM_COL];
  logic signed [ACC_WIDTH-1:0] acc     [NUM_ROW][NUM_COL];

  //====================================================================
  // Input skew, row r delayed by r steps
  //====================================================================
  for (genvar r = 0; r < NUM_ROW; r++) begin : g_row_skew
    if (r == 0) begin : g_direct
      assign row_act[r] = act_dat_i[r*ACT_WIDTH +: ACT_WIDTH];
      assign row_vld[r] = feed_vld_i;
    end else begin : g_delay
      logic [ACT_WIDTH-1:0] act_sr [r];
      logic [r-1:0]         vld_sr;

      always_ff @(posedge clk) begin
        if (step_i) begin
          act_sr[0] <= act_dat_i[r*ACT_WIDTH +: ACT_WIDTH];
          for (int i = 1; i < r; i++) begin
            act_sr[i] <= act_sr[i-1];
          end
        end
      end

      // Marks real data through the skew
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          vld_sr <= '0;
        end else if (step_i) begin
          vld_sr[0] <= feed_vld_i;
          for (int i = 1; i < r; i++) begin
            vld_sr[i] <= vld_sr[i-1];
          end
        end
      end

      assign row_act[r] = act_sr[r-1];
      assign row_vld[r] = vld_sr[r-1];
    end
  end

  // Column c weight delayed by c steps
  for (genvar c = 0; c < NUM_COL; c++) begin : g_col_skew
    if (c == 0) begin : g_direct
      assign col_wgt[c] = wgt_dat_i[c*ACT_WIDTH +: ACT_WIDTH];
    end else begin : g_delay
      logic [ACT_WIDTH-1:0] wgt_sr [c];

      always_ff @(posedge clk) begin
        if (step_i) begin
          wgt_sr[0] <= wgt_dat_i[c*ACT_WIDTH +: ACT_WIDTH];
          for (int i = 1; i < c; i++) begin
            wgt_sr[i] <= wgt_sr[i-1];
          end
        end
      end

      assign col_wgt[c] = wgt_sr[c-1];
    end
  end

  //====================================================================
  // PE grid
  //====================================================================
  for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
      assign act_in[r][c] = (c == 0) ? row_act[r] : act_out[r][(c > 0) ? c-1 : 0];
      assign vld_in[r][c] = (c == 0) ? row_vld[r] : vld_out[r][(c > 0) ? c-1 : 0];
      assign wgt_in[r][c] = (r == 0) ? col_wgt[c] : wgt_out[(r > 0) ? r-1 : 0][c];

      sya_pe u_pe (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (step_i),
        .clear_i (clear_i),
        .vld_i   (vld_in[r][c]),
        .act_i   (act_in[r][c]),
        .wgt_i   (wgt_in[r][c]),
        .vld_o   (vld_out[r][c]),
        .act_o   (act_out[r][c]),
        .wgt_o   (wgt_out[r][c]),
        .acc_o   (acc[r][c])
      );
    end
  end

  // Readout of the selected row
  for (genvar c = 0; c < NUM_COL; c++) begin : g_rd
    assign row_acc_o[c*ACC_WIDTH +: ACC_WIDTH] = acc[row_sel_i][c];
  end

endmodule

//--- hw/sya_pkg.sv
// Systolic engine shared definitions

package sya_pkg;

  //====================================================================
  // Datapath widths
  //====================================================================
  localparam int ACT_WIDTH   = 8;   // int8 activation, weight and output byte
  localparam int ACC_WIDTH   = 26;  // 16-bit product plus 10 bits of channel growth
  localparam int SCALE_WIDTH = 8;   // Unsigned multiplier
  localparam int SHIFT_WIDTH = 5;   // Right shift 0..31

  //====================================================================
  // Output saturation limits
  //====================================================================
  localparam logic signed [ACT_WIDTH-1:0] QMIN = -8'sd128;
  localparam logic signed [ACT_WIDTH-1:0] QMAX = 8'sd127;

endpackage

//--- hw/sya_top.sv
// Systolic matrix engine top level

`timescale 1ns/10ps

module sya_top
  import sya_pkg::*;
#(
  parameter  int NUM_ROW    = 4,
  parameter  int NUM_COL    = 4,
  parameter  int ADDR_WIDTH = 16,
  parameter  int CHN_WIDTH  = 10,
  localparam int SEL_WIDTH  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // Configuration
  input  logic                         cfg_vld_i,
  output logic                         cfg_rdy_o,
  input  logic [ADDR_WIDTH-1:0]        cfg_nip_i,
  input  logic [CHN_WIDTH-1:0]         cfg_chi_i,
  input  logic [SCALE_WIDTH-1:0]       cfg_scale_i,
  input  logic [SHIFT_WIDTH-1:0]       cfg_shift_i,
  input  logic [ACT_WIDTH-1:0]         cfg_zp_i,
  input  logic [ADDR_WIDTH-1:0]        cfg_act_base_i,
  input  logic [ADDR_WIDTH-1:0]        cfg_wgt_base_i,
  input  logic [ADDR_WIDTH-1:0]        cfg_ofm_base_i,
  // Buffer read side
  output logic [ADDR_WIDTH-1:0]        act_addr_o,
  output logic [ADDR_WIDTH-1:0]        wgt_addr_o,
  output logic                         rd_addr_vld_o,
  input  logic                         act_addr_rdy_i,
  input  logic                         wgt_addr_rdy_i,
  input  logic [ACT_WIDTH*NUM_ROW-1:0] act_dat_i,
  input  logic                         act_dat_vld_i,
  output logic                         act_dat_rdy_o,
  input  logic [ACT_WIDTH*NUM_COL-1:0] wgt_dat_i,
  input  logic                         wgt_dat_vld_i,
  output logic                         wgt_dat_rdy_o,
  // Output feature map write
  output logic [ACT_WIDTH*NUM_COL-1:0] ofm_dat_o,
  output logic [ADDR_WIDTH-1:0]        ofm_addr_o,
  output logic                         ofm_vld_o,
  input  logic                         ofm_rdy_i
);

  logic                         array_step, array_clear, feed_vld;
  logic                         tile_ready, tile_written;
  logic [SEL_WIDTH-1:0]         row_sel;
  logic [ACC_WIDTH*NUM_COL-1:0] row_acc;
  logic [SCALE_WIDTH-1:0]       scale;
  logic [SHIFT_WIDTH-1:0]       shift;
  logic [ACT_WIDTH-1:0]         zp;
  logic [ADDR_WIDTH-1:0]        ofm_base;

  sya_ctrl #(
    .NUM_ROW    (NUM_ROW),
    .NUM_COL    (NUM_COL),
    .ADDR_WIDTH (ADDR_WIDTH),
    .CHN_WIDTH  (CHN_WIDTH)
  ) u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_vld_i      (cfg_vld_i),
    .cfg_rdy_o      (cfg_rdy_o),
    .cfg_nip_i      (cfg_nip_i),
    .cfg_chi_i      (cfg_chi_i),
    .cfg_scale_i    (cfg_scale_i),
    .cfg_shift_i    (cfg_shift_i),
    .cfg_zp_i       (cfg_zp_i),
    .cfg_act_base_i (cfg_act_base_i),
    .cfg_wgt_base_i (cfg_wgt_base_i),
    .cfg_ofm_base_i (cfg_ofm_base_i),
    .act_addr_o     (act_addr_o),
    .wgt_addr_o     (wgt_addr_o),
    .rd_addr_vld_o  (rd_addr_vld_o),
    .act_addr_rdy_i (act_addr_rdy_i),
    .wgt_addr_rdy_i (wgt_addr_rdy_i),
    .act_dat_vld_i  (act_dat_vld_i),
    .act_dat_rdy_o  (act_dat_rdy_o),
    .wgt_dat_vld_i  (wgt_dat_vld_i),
    .wgt_dat_rdy_o  (wgt_dat_rdy_o),
    .array_step_o   (array_step),
    .array_clear_o  (array_clear),
    .feed_vld_o     (feed_vld),
    .tile_ready_o   (tile_ready),
    .tile_written_i (tile_written),
    .scale_o        (scale),
    .shift_o        (shift),
    .zp_o           (zp),
    .ofm_base_o     (ofm_base)
  );

  sya_pe_array #(
    .NUM_ROW (NUM_ROW),
    .NUM_COL (NUM_COL)
  ) u_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .step_i     (array_step),
    .clear_i    (array_clear),
    .feed_vld_i (feed_vld),
    .act_dat_i  (act_dat_i),
    .wgt_dat_i  (wgt_dat_i),
    .row_sel_i  (row_sel),
    .row_acc_o  (row_acc)
  );

  sya_ofm_writer #(
    .NUM_ROW    (NUM_ROW),
    .NUM_COL    (NUM_COL),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_writer (
    .clk            (clk),
    .rst_n          (rst_n),
    .tile_ready_i   (tile_ready),
    .row_acc_i      (row_acc),
    .scale_i        (scale),
    .shift_i        (shift),
    .zp_i           (zp),
    .ofm_base_i     (ofm_base),
    .ofm_rdy_i      (ofm_rdy_i),
    .row_sel_o      (row_sel),
    .ofm_dat_o      (ofm_dat_o),
    .ofm_addr_o     (ofm_addr_o),
    .ofm_vld_o      (ofm_vld_o),
    .tile_written_o (tile_written)
  );

endmodule

//--- sim.f
+incdir+testbench
hw/sya_pkg.sv
hw/sya_pe.sv
hw/sya_pe_array.sv
hw/sya_ctrl.sv
hw/sya_ofm_writer.sv
hw/sya_top.sv
testbench/tb_sya.sv

//--- testbench/sya_ref.svh
// Systolic engine reference model

`ifndef SYA_REF_SVH
`define SYA_REF_SVH

// Uses act_mem, wgt_mem and the cmd_* command state of the including module

// Lane b of a packed int8 word, sign extended
function automatic int lane_value(input logic [63:0] word, input int b);
  return int'($signed(word[b*ACT_WIDTH +: ACT_WIDTH]));
endfunction

// Accumulator of PE(r,c) at the end of tile t
function automatic longint ref_acc(input int t, input int r, input int c);
  longint acc;
  int     idx;
  acc = 0;
  for (int k = 0; k < cmd_chi; k++) begin
    idx = t * cmd_chi + k;   // Channel index over the whole command
    acc += longint'(lane_value(act_mem[(cmd_act_base + idx) % MEM_DEPTH], r)) *
           longint'(lane_value(wgt_mem[(cmd_wgt_base + idx) % MEM_DEPTH], c));
  end
  return acc;
endfunction

// Scale, floor shift, zero point, clamp to int8
function automatic int ref_quant(input longint acc, input int scale, input int shift,
                                 input int zp);
  longint val;
  val = (acc * scale) >>> shift;
  val = val + zp;
  if (val > longint'(QMAX)) begin
    return int'(QMAX);
  end else if (val < longint'(QMIN)) begin
    return int'(QMIN);
  end
  return int'(val);
endfunction

// Expected output word for row r of tile t
function automatic logic [ACT_WIDTH*NUM_COL-1:0] expected_word(input int t, input int r);
  logic [ACT_WIDTH*NUM_COL-1:0] word;
  for (int c = 0; c < NUM_COL; c++) begin
    word[c*ACT_WIDTH +: ACT_WIDTH] =
      ACT_WIDTH'(ref_quant(ref_acc(t, r, c), cmd_scale, cmd_shift, cmd_zp));
  end
  return word;
endfunction

`endif

//--- testbench/tb_sya.sv
// Systolic engine testbench

`timescale 1ns/10ps

module tb_sya
  import sya_pkg::*;
();

  localparam int NUM_ROW     = 4;
  localparam int NUM_COL     = 4;
  localparam int ADDR_WIDTH  = 16;
  localparam int CHN_WIDTH   = 10;
  localparam int MEM_DEPTH   = 1 << ADDR_WIDTH;
  localparam int CFG_TIMEOUT = 100;     // Cycles
  localparam int RUN_TIMEOUT = 20000;

  logic                         clk, rst_n;
  logic                         cfg_vld_i, cfg_rdy_o;
  logic [ADDR_WIDTH-1:0]        cfg_nip_i;
  logic [CHN_WIDTH-1:0]         cfg_chi_i;
  logic [SCALE_WIDTH-1:0]       cfg_scale_i;
  logic [SHIFT_WIDTH-1:0]       cfg_shift_i;
  logic [ACT_WIDTH-1:0]         cfg_zp_i;
  logic [ADDR_WIDTH-1:0]        cfg_act_base_i, cfg_wgt_base_i, cfg_ofm_base_i;
  logic [ADDR_WIDTH-1:0]        act_addr_o, wgt_addr_o;
  logic                         rd_addr_vld_o, act_addr_rdy_i, wgt_addr_rdy_i;
  logic [ACT_WIDTH*NUM_ROW-1:0] act_dat_i;
  logic                         act_dat_vld_i, act_dat_rdy_o;
  logic [ACT_WIDTH*NUM_COL-1:0] wgt_dat_i;
  logic                         wgt_dat_vld_i, wgt_dat_rdy_o;
  logic [ACT_WIDTH*NUM_COL-1:0] ofm_dat_o;
  logic [ADDR_WIDTH-1:0]        ofm_addr_o;
  logic                         ofm_vld_o, ofm_rdy_i;

  // Buffer contents
  logic [ACT_WIDTH*NUM_ROW-1:0] act_mem [MEM_DEPTH];
  logic [ACT_WIDTH*NUM_COL-1:0] wgt_mem [MEM_DEPTH];

  // Current command as seen by the scoreboard
  int cmd_nip, cmd_chi, cmd_scale, cmd_shift, cmd_zp;
  int cmd_act_base, cmd_wgt_base, cmd_ofm_base;
  int rd_cnt, out_cnt, seen_qmin, seen_qmax;
  bit cmd_busy, rdy_due, bp_en, aborted;
  int err_cnt, test_cnt, bad_tests;
  integer      seed;
  int unsigned cycle;

  // Outstanding reads with their due cycles
  logic [ADDR_WIDTH-1:0] act_req_q [$];
  logic [ADDR_WIDTH-1:0] wgt_req_q [$];
  int unsigned           act_due_q [$];
  int unsigned           wgt_due_q [$];

  `include "sya_ref.svh"

  sya_top #(
    .NUM_ROW    (NUM_ROW),
    .NUM_COL    (NUM_COL),
    .ADDR_WIDTH (ADDR_WIDTH),
    .CHN_WIDTH  (CHN_WIDTH)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_vld_i      (cfg_vld_i),
    .cfg_rdy_o      (cfg_rdy_o),
    .cfg_nip_i      (cfg_nip_i),
    .cfg_chi_i      (cfg_chi_i),
    .cfg_scale_i    (cfg_scale_i),
    .cfg_shift_i    (cfg_shift_i),
    .cfg_zp_i       (cfg_zp_i),
    .cfg_act_base_i (cfg_act_base_i),
    .cfg_wgt_base_i (cfg_wgt_base_i),
    .cfg_ofm_base_i (cfg_ofm_base_i),
    .act_addr_o     (act_addr_o),
    .wgt_addr_o     (wgt_addr_o),
    .rd_addr_vld_o  (rd_addr_vld_o),
    .act_addr_rdy_i (act_addr_rdy_i),
    .wgt_addr_rdy_i (wgt_addr_rdy_i),
    .act_dat_i      (act_dat_i),
    .act_dat_vld_i  (act_dat_vld_i),
    .act_dat_rdy_o  (act_dat_rdy_o),
    .wgt_dat_i      (wgt_dat_i),
    .wgt_dat_vld_i  (wgt_dat_vld_i),
    .wgt_dat_rdy_o  (wgt_dat_rdy_o),
    .ofm_dat_o      (ofm_dat_o),
    .ofm_addr_o     (ofm_addr_o),
    .ofm_vld_o      (ofm_vld_o),
    .ofm_rdy_i      (ofm_rdy_i)
  );

  always #10 clk = ~clk;   // 20 ns period

  //======================================================================
  // Helpers
  //======================================================================
  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before && !aborted) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      bad_tests++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // Configure one command and wait until the engine is idle again
  task automatic run_command(input int nip, input int chi, input int scale, input int shift,
                             input int zp, input int act_base, input int wgt_base,
                             input int ofm_base);
    int waited;
    if (aborted) begin
      return;
    end
    @(posedge clk);
    #1;
    cmd_nip      = nip;
    cmd_chi      = chi;
    cmd_scale    = scale;
    cmd_shift    = shift;
    cmd_zp       = zp;
    cmd_act_base = act_base;
    cmd_wgt_base = wgt_base;
    cmd_ofm_base = ofm_base;
    rd_cnt       = 0;
    out_cnt      = 0;
    cfg_vld_i      = 1'b1;
    cfg_nip_i      = ADDR_WIDTH'(nip);
    cfg_chi_i      = CHN_WIDTH'(chi);
    cfg_scale_i    = SCALE_WIDTH'(scale);
    cfg_shift_i    = SHIFT_WIDTH'(shift);
    cfg_zp_i       = ACT_WIDTH'(zp);
    cfg_act_base_i = ADDR_WIDTH'(act_base);
    cfg_wgt_base_i = ADDR_WIDTH'(wgt_base);
    cfg_ofm_base_i = ADDR_WIDTH'(ofm_base);
    waited = 0;
    @(negedge clk);
    while (!cfg_rdy_o && waited < CFG_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!cfg_rdy_o) begin
      $display("timeout at %0d ns: the engine did not accept the configuration", $time);
      aborted = 1'b1;
      return;
    end
    @(posedge clk);   // Configuration taken on this edge
    #1;
    cfg_vld_i = 1'b0;
    waited    = 0;
    @(negedge clk);
    while (!cfg_rdy_o && waited < RUN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!cfg_rdy_o) begin
      $display("timeout at %0d ns: the command did not complete", $time);
      aborted = 1'b1;
      return;
    end
    check_value("read addresses issued", rd_cnt, nip * chi);
    check_value("output words written", out_cnt, nip * NUM_ROW);
  endtask

  //======================================================================
  // In-order activation and weight buffers with 0..3 cycles of delay
  //======================================================================
  initial begin : buffer_model
    int delay;
    cycle = 0;
    forever begin
      @(negedge clk);
      if (rst_n && rd_addr_vld_o && act_addr_rdy_i && wgt_addr_rdy_i) begin
        delay = $unsigned($random(seed)) % 4;
        act_req_q.push_back(act_addr_o);
        act_due_q.push_back(cycle + 1 + delay);
        delay = $unsigned($random(seed)) % 4;
        wgt_req_q.push_back(wgt_addr_o);
        wgt_due_q.push_back(cycle + 1 + delay);
      end
      if (act_dat_vld_i && act_dat_rdy_o) begin
        void'(act_req_q.pop_front());
        void'(act_due_q.pop_front());
      end
      if (wgt_dat_vld_i && wgt_dat_rdy_o) begin
        void'(wgt_req_q.pop_front());
        void'(wgt_due_q.pop_front());
      end
      @(posedge clk);
      cycle++;
      #1;
      act_dat_vld_i  = (act_req_q.size() > 0) && (act_due_q[0] <= cycle);
      act_dat_i      = act_dat_vld_i ? act_mem[act_req_q[0]] : '0;
      wgt_dat_vld_i  = (wgt_req_q.size() > 0) && (wgt_due_q[0] <= cycle);
      wgt_dat_i      = wgt_dat_vld_i ? wgt_mem[wgt_req_q[0]] : '0;
      act_addr_rdy_i = bp_en ? 1'($random(seed)) : 1'b1;
      wgt_addr_rdy_i = bp_en ? 1'($random(seed)) : 1'b1;
      ofm_rdy_i      = bp_en ? 1'($random(seed)) : 1'b1;
    end
  end

  //======================================================================
  // Scoreboard on read addresses and output words
  //======================================================================
  initial begin : output_check
    logic [ACT_WIDTH*NUM_COL-1:0] exp_word;
    forever begin
      @(negedge clk);
      if (rdy_due) begin
        check_value("cfg_rdy_o after the last word", cfg_rdy_o, 1'b1);
        rdy_due = 1'b0;
      end
      if (cmd_busy) begin
        check_value("cfg_rdy_o during a command", cfg_rdy_o, 1'b0);
      end
      if (cfg_vld_i && cfg_rdy_o) begin
        cmd_busy = 1'b1;
      end
      if (rd_addr_vld_o && act_addr_rdy_i && wgt_addr_rdy_i) begin
        check_value("activation read address", act_addr_o,
                    (cmd_act_base + rd_cnt) % MEM_DEPTH);
        check_value("weight read address", wgt_addr_o, (cmd_wgt_base + rd_cnt) % MEM_DEPTH);
        rd_cnt++;
      end
      if (ofm_vld_o && ofm_rdy_i) begin
        exp_word = expected_word(out_cnt / NUM_ROW, out_cnt % NUM_ROW);
        check_value("output address", ofm_addr_o, (cmd_ofm_base + out_cnt) % MEM_DEPTH);
        check_value("output word", ofm_dat_o, exp_word);
        for (int c = 0; c < NUM_COL; c++) begin
          if (ofm_dat_o[c*ACT_WIDTH +: ACT_WIDTH] == QMIN) seen_qmin++;
          if (ofm_dat_o[c*ACT_WIDTH +: ACT_WIDTH] == QMAX) seen_qmax++;
        end
        out_cnt++;
        if (out_cnt == cmd_nip * NUM_ROW) begin
          cmd_busy = 1'b0;   // Last word of the command
          rdy_due  = 1'b1;
        end
      end
    end
  end

  //======================================================================
  // Test sequence
  //======================================================================
  initial begin : main_sequence
    int errs;
    clk            = 1'b0;
    rst_n          = 1'b0;
    cfg_vld_i      = 1'b0;
    cfg_nip_i      = '0;
    cfg_chi_i      = '0;
    cfg_scale_i    = '0;
    cfg_shift_i    = '0;
    cfg_zp_i       = '0;
    cfg_act_base_i = '0;
    cfg_wgt_base_i = '0;
    cfg_ofm_base_i = '0;
    act_addr_rdy_i = 1'b1;
    wgt_addr_rdy_i = 1'b1;
    act_dat_i      = '0;
    act_dat_vld_i  = 1'b0;
    wgt_dat_i      = '0;
    wgt_dat_vld_i  = 1'b0;
    ofm_rdy_i      = 1'b1;
    seed      = 5018;
    cmd_busy  = 1'b0;
    rdy_due   = 1'b0;
    bp_en     = 1'b0;
    aborted   = 1'b0;
    err_cnt   = 0;
    test_cnt  = 0;
    bad_tests = 0;
    seen_qmin = 0;
    seen_qmax = 0;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      act_mem[a] = $random(seed);
      wgt_mem[a] = $random(seed);
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);

    errs = err_cnt;   // Idle outputs after reset and one tile
    check_value("cfg_rdy_o after reset", cfg_rdy_o, 1'b1);
    check_value("rd_addr_vld_o after reset", rd_addr_vld_o, 1'b0);
    check_value("act_dat_rdy_o after reset", act_dat_rdy_o, 1'b0);
    check_value("wgt_dat_rdy_o after reset", wgt_dat_rdy_o, 1'b0);
    check_value("ofm_vld_o after reset", ofm_vld_o, 1'b0);
    run_command(1, 5, 1, 0, 0, 'h0100, 'h0200, 'h0300);
    report_test("single tile", errs);

    errs = err_cnt;
    run_command(3, 7, 5, 9, 3, 'h1000, 'h2000, 'h3000);
    report_test("multi tile", errs);

    errs  = err_cnt;
    bp_en = 1'b1;
    run_command(4, 6, 5, 9, -2, 'h4000, 'h5000, 'h6000);
    bp_en = 1'b0;
    report_test("back-pressure", errs);

    errs      = err_cnt;
    seen_qmin = 0;
    seen_qmax = 0;
    run_command(2, 8, 200, 6, -20, 'h7000, 'h7800, 'h8000);
    check_value("lanes clamped to QMIN", seen_qmin > 0, 1'b1);
    check_value("lanes clamped to QMAX", seen_qmax > 0, 1'b1);
    report_test("saturation", errs);

    errs = err_cnt;   // Two commands back to back
    run_command(2, 3, 7, 8, 10, 'h9000, 'h9800, 'hA000);
    run_command(1, 4, 9, 7, -5, 'hB000, 'hB800, 'hC000);
    report_test("reconfiguration", errs);

    $display("tests %0d, tests with errors %0d, mismatches %0d", test_cnt, bad_tests,
             err_cnt);
    if (err_cnt == 0 && bad_tests == 0 && !aborted) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
